// File: trace_pkg.sv
/*
 * Shared widths, CSR bit offsets and record types of the core trace unit.
 * Every trace module imports this package.
 */
package trace_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_count  = 7;
    localparam int stamp_w    = 32;

    // CSR bit offsets
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11;
    localparam int msi_bit          = 3;
    localparam int mti_bit          = 7;
    localparam int mei_bit          = 11;

    // ----------------------------------------
    // Core side port groups
    // ----------------------------------------
    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } reg_wr_s;

    typedef struct packed {
        logic            en;
        logic [xlen-1:0] pc;
    } pc_upd_s;

    typedef struct packed {
        logic        mstatus_mie;
        logic        mstatus_mpie;
        logic        mie_msie;
        logic        mie_mtie;
        logic        mie_meie;
        logic        mip_msip;
        logic        mip_mtip;
        logic        mip_meip;
        logic        mtvec_mode;
        logic        mcause_irq;
        logic [25:0] mtvec_base;   // Bits 31:6
        logic [30:0] mepc;         // Bits 31:1
        logic [30:0] mcause_code;
        logic [31:0] mtval;
    } csr_fields_s;

    typedef enum logic [2:0] {
        CSR_MSTATUS = 3'd0,
        CSR_MTVEC   = 3'd1,
        CSR_MIE     = 3'd2,
        CSR_MIP     = 3'd3,
        CSR_MEPC    = 3'd4,
        CSR_MCAUSE  = 3'd5,
        CSR_MTVAL   = 3'd6
    } csr_id_e;

    // ----------------------------------------
    // Trace records
    // ----------------------------------------
    typedef enum logic [1:0] {
        REC_REG = 2'd0,
        REC_PC  = 2'd1,
        REC_CSR = 2'd2
    } rec_kind_e;

    typedef struct packed {
        rec_kind_e             kind;
        logic [stamp_w-1:0]    stamp;
        logic [reg_addr_w-1:0] idx;
        logic [xlen-1:0]       data;
    } trace_rec_s;

    typedef struct packed {
        rec_kind_e             kind;
        logic [reg_addr_w-1:0] idx;
        logic [xlen-1:0]       data;
    } trace_event_s;

    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_REQ,
        LINK_RELEASE
    } link_state_e;

endpackage

// File: reg_shadow.sv
/*
 * Shadow copy of the integer register file with a registered debug read.
 * Turns each sampled register write or PC update into one trace event.
 */
`timescale 1ns/1ps

module reg_shadow import trace_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_wr_s               reg_wr,
    input  pc_upd_s               pc_upd,
    input  logic [reg_addr_w-1:0] dbg_addr,
    output logic [xlen-1:0]       dbg_data,
    output logic                  ev_valid,
    output trace_event_s          ev
);

    logic [xlen-1:0] shadow_q [1:31];   // x0 has no storage
    logic            wr_hit;

    assign wr_hit = reg_wr.en && (reg_wr.addr != '0);

    // ----------------------------------------
    // Shadow registers and debug read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                shadow_q[i] <= '0;
            end
            dbg_data <= '0;
        end else begin
            if (wr_hit) begin
                shadow_q[reg_wr.addr] <= reg_wr.data;
            end
            dbg_data <= (dbg_addr == '0) ? '0 : shadow_q[dbg_addr];
        end
    end

    // ----------------------------------------
    // Event generation
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= wr_hit || pc_upd.en;
        end
    end

    // Register write wins over a PC update in the same cycle
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            ev.kind <= REC_REG;
            ev.idx  <= reg_wr.addr;
            ev.data <= reg_wr.data;
        end else begin
            ev.kind <= REC_PC;
            ev.idx  <= '0;
            ev.data <= pc_upd.pc;
        end
    end

endmodule

// File: csr_snapshot.sv
/*
 * Packs the machine-mode CSR fields into full words and watches them for changes.
 * Changed CSRs are queued in a pending mask and offered one at a time, lowest id first.
 */
`timescale 1ns/1ps

module csr_snapshot import trace_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  csr_fields_s  csr_in,
    input  logic         csr_ready,
    output logic         csr_valid,
    output trace_event_s csr_ev
);

    logic [csr_count-1:0][xlen-1:0] cur_w;
    logic [csr_count-1:0][xlen-1:0] snap_q;   // Newest sampled words
    logic [csr_count-1:0]           chg;
    logic [csr_count-1:0]           pend_q;
    logic [csr_count-1:0]           take_mask;
    logic                           base_q;   // Baseline captured
    csr_id_e                        sel;

    // ----------------------------------------
    // Word packing
    // ----------------------------------------
    always_comb begin
        cur_w = '0;
        cur_w[CSR_MSTATUS][mstatus_mie_bit]                      = csr_in.mstatus_mie;
        cur_w[CSR_MSTATUS][mstatus_mpie_bit]                     = csr_in.mstatus_mpie;
        cur_w[CSR_MSTATUS][mstatus_mpp_lsb+1:mstatus_mpp_lsb]    = 2'b11; // M-mode only
        cur_w[CSR_MTVEC]   = {csr_in.mtvec_base, 5'b0, csr_in.mtvec_mode};
        cur_w[CSR_MIE][msi_bit] = csr_in.mie_msie;
        cur_w[CSR_MIE][mti_bit] = csr_in.mie_mtie;
        cur_w[CSR_MIE][mei_bit] = csr_in.mie_meie;
        cur_w[CSR_MIP][msi_bit] = csr_in.mip_msip;
        cur_w[CSR_MIP][mti_bit] = csr_in.mip_mtip;
        cur_w[CSR_MIP][mei_bit] = csr_in.mip_meip;
        cur_w[CSR_MEPC]    = {csr_in.mepc, 1'b0};
        cur_w[CSR_MCAUSE]  = {csr_in.mcause_irq, csr_in.mcause_code};
        cur_w[CSR_MTVAL]   = csr_in.mtval;
    end

    // ----------------------------------------
    // Change detection and pending mask
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < csr_count; i++) begin
            chg[i] = base_q && (cur_w[i] != snap_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        snap_q <= cur_w;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            base_q <= 1'b0;
            pend_q <= '0;
        end else begin
            base_q <= 1'b1;
            pend_q <= (pend_q & ~take_mask) | chg;   // New change keeps it pending
        end
    end

    // ----------------------------------------
    // Lowest pending CSR offered
    // ----------------------------------------
    always_comb begin
        sel = CSR_MSTATUS;
        for (int i = csr_count - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                sel = csr_id_e'(3'(i));
            end
        end
    end

    assign csr_valid   = |pend_q;
    assign take_mask   = (csr_valid && csr_ready) ? (csr_count'(1) << sel) : '0;
    assign csr_ev.kind = REC_CSR;
    assign csr_ev.idx  = {2'b00, sel};
    assign csr_ev.data = snap_q[sel];

    // Offer holds across a stall while no CSR changes underneath it
    a_csr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        csr_valid && !csr_ready && (chg == '0) |=> $stable(csr_ev));

endmodule

// File: trace_merge.sv
/*
 * Stamps trace events with the cycle count and pushes them into the record FIFO.
 * Register/PC events have priority and are dropped when the FIFO is full.
 * CSR events wait on csr_ready instead.
 */
`timescale 1ns/1ps

module trace_merge import trace_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         ev_valid,
    input  trace_event_s ev,
    input  logic         csr_valid,
    input  trace_event_s csr_ev,
    input  logic         full,
    output logic         csr_ready,
    output logic         push,
    output trace_rec_s   push_rec,
    output logic [15:0]  drop_count
);

    logic [stamp_w-1:0] cycle_q;
    logic               drop;
    trace_event_s       pick;

    // ----------------------------------------
    // Free-running cycle counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    // ----------------------------------------
    // Source selection
    // ----------------------------------------
    assign csr_ready = !ev_valid && !full;
    assign drop      = ev_valid && full;
    assign push      = (ev_valid && !full) || (csr_valid && csr_ready);
    assign pick      = ev_valid ? ev : csr_ev;

    always_comb begin
        push_rec.kind  = pick.kind;
        push_rec.stamp = cycle_q;
        push_rec.idx   = pick.idx;
        push_rec.data  = pick.data;
    end

    // Saturating drop count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && (drop_count != 16'hffff)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // CSR offer that is not taken stays offered
    a_csr_waits: assert property (@(posedge clk) disable iff (!rst_n)
        csr_valid && !csr_ready |=> csr_valid);

endmodule

// File: trace_fifo.sv
/*
 * Synchronous circular FIFO of trace records.
 * Depth comes from FIFO_DEPTH; head shows the oldest record while not empty.
 */
`timescale 1ns/1ps

module trace_fifo import trace_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  trace_rec_s push_rec,
    input  logic       pop,
    output trace_rec_s head,
    output logic       empty,
    output logic       full
);

    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    trace_rec_s       mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(FIFO_DEPTH));
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty));

endmodule

// File: trace_link.sv
/*
 * Four-phase req/ack sender that drains the record FIFO.
 * The head record is latched before req rises and popped once ack is seen.
 */
`timescale 1ns/1ps

module trace_link import trace_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       empty,
    input  trace_rec_s head,
    input  logic       trace_ack,
    output logic       pop,
    output logic       trace_req,
    output trace_rec_s trace_rec
);

    link_state_e state_q;
    logic        start;

    // Next record may go only once ack is back low
    assign start     = !empty && !trace_ack && (state_q != LINK_REQ);
    assign trace_req = (state_q == LINK_REQ);
    assign pop       = (state_q == LINK_REQ) && trace_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= LINK_IDLE;
        end else begin
            case (state_q)
                LINK_IDLE:    if (start) state_q <= LINK_REQ;
                LINK_REQ:     if (trace_ack) state_q <= LINK_RELEASE;
                LINK_RELEASE: if (!trace_ack) state_q <= start ? LINK_REQ : LINK_IDLE;
                default:      state_q <= LINK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            trace_rec <= head;
        end
    end

    a_rec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        trace_req |=> !trace_req || $stable(trace_rec));

endmodule

// File: trace_top.sv
/*
 * Top level of the core trace unit.
 * Connects register shadow, CSR snapshot, merge, record FIFO and link sender.
 */
`timescale 1ns/1ps

module trace_top import trace_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_wr_s               reg_wr,
    input  pc_upd_s               pc_upd,
    input  csr_fields_s           csr_in,
    input  logic [reg_addr_w-1:0] dbg_addr,
    input  logic                  trace_ack,
    output logic [xlen-1:0]       dbg_data,
    output logic                  trace_req,
    output trace_rec_s            trace_rec,
    output logic [15:0]           drop_count
);

    logic         ev_valid;
    trace_event_s ev;
    logic         csr_valid;
    logic         csr_ready;
    trace_event_s csr_ev;
    logic         push;
    trace_rec_s   push_rec;
    logic         full;
    logic         empty;
    logic         pop;
    trace_rec_s   head;

    // ----------------------------------------
    // Event sources
    // ----------------------------------------
    reg_shadow reg_shadow_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_wr   (reg_wr),
        .pc_upd   (pc_upd),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data),
        .ev_valid (ev_valid),
        .ev       (ev)
    );

    csr_snapshot csr_snapshot_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_in    (csr_in),
        .csr_ready (csr_ready),
        .csr_valid (csr_valid),
        .csr_ev    (csr_ev)
    );

    // ----------------------------------------
    // Record path
    // ----------------------------------------
    trace_merge trace_merge_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ev_valid   (ev_valid),
        .ev         (ev),
        .csr_valid  (csr_valid),
        .csr_ev     (csr_ev),
        .full       (full),
        .csr_ready  (csr_ready),
        .push       (push),
        .push_rec   (push_rec),
        .drop_count (drop_count)
    );

    trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) trace_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_rec (push_rec),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .full     (full)
    );

    trace_link trace_link_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .head      (head),
        .trace_ack (trace_ack),
        .pop       (pop),
        .trace_req (trace_req),
        .trace_rec (trace_rec)
    );

endmodule

// File: tb_clk_gen.sv
/*
 * Testbench clock and reset source.
 * 4 ns clock, rst_n held low for the first 10 cycles.
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // Released on a falling edge
    end

endmodule

// File: tb_trace_top.sv
/*
 * Testbench for the core trace unit.
 * Random register, PC and CSR stimulus, a four-phase link receiver and a
 * record checker fed by reference functions.
 */
`timescale 1ns/1ps

module tb_trace_top import trace_pkg::*; ();

    logic        clk;
    logic        rst_n;
    reg_wr_s     reg_wr;
    pc_upd_s     pc_upd;
    csr_fields_s csr_in;
    logic [4:0]  dbg_addr;
    logic        trace_ack = 1'b0;
    logic [31:0] dbg_data;
    logic        trace_req;
    trace_rec_s  trace_rec;
    logic [15:0] drop_count;

    integer      seed = 32'h73ee57fe;
    trace_rec_s  exp_q[$];
    trace_rec_s  rx_q[$];
    logic [31:0] shadow [32];   // Expected register contents
    logic [31:0] last_stamp;
    int          errors;
    int          tests;
    int          failed_tests;
    int          rx_reg_count;
    int          skipped;       // Expected records passed over as dropped
    bit          hold_ack;
    bit          ack_linger;
    bit          allow_skip;
    bit          have_stamp;
    bit          timed_out;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    trace_top #(
        .FIFO_DEPTH (8)
    ) trace_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .pc_upd     (pc_upd),
        .csr_in     (csr_in),
        .dbg_addr   (dbg_addr),
        .trace_ack  (trace_ack),
        .dbg_data   (dbg_data),
        .trace_req  (trace_req),
        .trace_rec  (trace_rec),
        .drop_count (drop_count)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [31:0] expected_csr_word(input csr_fields_s f, input int id);
        logic [31:0] w;
        w = '0;
        case (id)
            0: begin
                w[3]     = f.mstatus_mie;
                w[7]     = f.mstatus_mpie;
                w[12:11] = 2'b11;   // MPP fixed to M-mode
            end
            1: w = {f.mtvec_base, 5'b0, f.mtvec_mode};
            2: begin
                w[3]  = f.mie_msie;
                w[7]  = f.mie_mtie;
                w[11] = f.mie_meie;
            end
            3: begin
                w[3]  = f.mip_msip;
                w[7]  = f.mip_mtip;
                w[11] = f.mip_meip;
            end
            4: w = {f.mepc, 1'b0};
            5: w = {f.mcause_irq, f.mcause_code};
            6: w = f.mtval;
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic bit expected_record(input reg_wr_s w, input pc_upd_s p,
                                           output trace_rec_s r);
        r = '0;
        if (w.en && w.addr != 5'd0) begin   // Write beats PC update
            r.kind = REC_REG;
            r.idx  = w.addr;
            r.data = w.data;
            return 1'b1;
        end
        if (p.en) begin
            r.kind = REC_PC;
            r.data = p.pc;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic bit same_content(input trace_rec_s a, input trace_rec_s b);
        return a.kind == b.kind && a.idx == b.idx && a.data == b.data;
    endfunction

    function automatic csr_fields_s random_fields();
        logic [159:0] raw;
        raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        return raw[$bits(csr_fields_s)-1:0];
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic drive_cycle(input reg_wr_s w, input pc_upd_s p);
        trace_rec_s r;
        @(negedge clk);
        reg_wr = w;
        pc_upd = p;
        if (expected_record(w, p, r)) exp_q.push_back(r);
        if (w.en && w.addr != 5'd0) shadow[w.addr] = w.data;
    endtask

    task automatic push_csr(input csr_fields_s f, input int id);
        trace_rec_s r;
        r      = '0;
        r.kind = REC_CSR;
        r.idx  = 5'(id);
        r.data = expected_csr_word(f, id);
        exp_q.push_back(r);
    endtask

    task automatic apply_csr(input csr_fields_s nxt);
        @(negedge clk);
        for (int i = 0; i < 7; i++) begin
            if (expected_csr_word(nxt, i) != expected_csr_word(csr_in, i)) push_csr(nxt, i);
        end
        csr_in = nxt;
    endtask

    // Wait until every expected record has come back, then idle a while
    task automatic settle(input string what);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || rx_q.size() != 0) && n < 600) begin
            @(posedge clk);
            n++;
        end
        if (n >= 600) begin
            $display("Timeout: records of %s never arrived (%0d missing)", what, exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
        repeat (20) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED", tests, name);
        end
    endtask

    // ----------------------------------------
    // Link receiver and record checker
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n && trace_ack && trace_req) report_error("trace_req high while trace_ack high");
        if (!rst_n) begin
            trace_ack = 1'b0;
        end else if (trace_ack) begin
            if (!trace_req) begin
                if (ack_linger) begin
                    ack_linger = 1'b0;   // Ack stays high one more cycle
                end else begin
                    trace_ack = 1'b0;
                end
            end
        end else if (trace_req && !hold_ack) begin
            rx_q.push_back(trace_rec);
            trace_ack  = 1'b1;
            ack_linger = 1'b1;
        end
    end

    always @(posedge clk) begin : compare_records
        trace_rec_s got;
        trace_rec_s want;
        if (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (have_stamp && got.stamp <= last_stamp) begin
                report_error($sformatf("stamp %0d not above %0d", got.stamp, last_stamp));
            end
            last_stamp = got.stamp;
            have_stamp = 1'b1;
            if (got.kind == REC_REG) rx_reg_count++;
            // Dropped register records are skipped during a stall
            while (allow_skip && exp_q.size() > 0 && exp_q[0].kind == REC_REG &&
                   !same_content(exp_q[0], got)) begin
                want = exp_q.pop_front();
                skipped++;
            end
            if (exp_q.size() == 0) begin
                report_error($sformatf("unexpected record kind %0d idx %0d data %h",
                                       got.kind, got.idx, got.data));
            end else begin
                want = exp_q.pop_front();
                if (got.kind != want.kind) begin
                    report_error($sformatf("kind %0d, expected %0d", got.kind, want.kind));
                end
                if (got.idx != want.idx) begin
                    report_error($sformatf("idx %0d, expected %0d", got.idx, want.idx));
                end
                if (got.data != want.data) begin
                    report_error($sformatf("data %h, expected %h", got.data, want.data));
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        reg_wr_s     w;
        pc_upd_s     p;
        int          start_errors;
        int          start_rx_reg;
        int          start_skip;
        int          n;
        logic [15:0] start_drops;
        logic [15:0] stall_drops;
        reg_wr   = '0;
        pc_upd   = '0;
        dbg_addr = '0;
        csr_in   = random_fields();
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        n = 0;
        while (!rst_n && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("Reset was never released");
            errors++;
            timed_out = 1'b1;
        end

        if (!timed_out) begin   // Register writes, some to x0
            start_errors = errors;
            for (int i = 0; i < 40; i++) begin
                w.en   = 1'b1;
                w.addr = (i % 4 == 0) ? 5'd0 : 5'($random(seed));
                w.data = $random(seed);
                p.en   = (i % 4 == 0) ? 1'($random(seed)) : 1'b0;
                p.pc   = $random(seed);
                drive_cycle(w, p);
                repeat (3) drive_cycle('0, '0);   // Slower than the link drains
            end
            drive_cycle('0, '0);
            settle("register writes");
            finish_test("register writes", start_errors);
        end

        if (!timed_out) begin   // PC updates with and without writes
            start_errors = errors;
            for (int i = 0; i < 30; i++) begin
                w.en   = 1'($random(seed));
                w.addr = 5'($random(seed));
                w.data = $random(seed);
                p.en   = 1'b1;
                p.pc   = $random(seed);
                drive_cycle(w, p);
                repeat (3) drive_cycle('0, '0);
            end
            drive_cycle('0, '0);
            settle("pc updates");
            finish_test("pc updates", start_errors);
        end

        if (!timed_out) begin   // Debug reads
            start_errors = errors;
            for (int a = 1; a < 32; a++) begin
                w.en   = 1'b1;
                w.addr = 5'(a);
                w.data = $random(seed);
                drive_cycle(w, '0);
                repeat (3) drive_cycle('0, '0);
            end
            drive_cycle('0, '0);
            settle("shadow fill");
            for (int a = 0; a < 32; a++) begin
                @(negedge clk);
                dbg_addr = 5'(a);
                @(negedge clk);
                if (dbg_data !== shadow[a]) begin
                    report_error($sformatf("dbg x%0d read %h, expected %h",
                                           a, dbg_data, shadow[a]));
                end
            end
            finish_test("debug reads", start_errors);
        end

        if (!timed_out) begin   // CSR changes
            start_errors = errors;
            for (int r = 0; r < 6; r++) begin
                if (r == 0) apply_csr(~csr_in);
                else if (r == 2) apply_csr(csr_in);   // No change at all
                else apply_csr(csr_in ^ (random_fields() & random_fields() & random_fields()));
                settle("csr changes");
            end
            finish_test("csr changes", start_errors);
        end

        if (!timed_out) begin   // Stalled link
            start_errors = errors;
            start_drops  = drop_count;
            start_rx_reg = rx_reg_count;
            start_skip   = skipped;
            hold_ack     = 1'b1;
            allow_skip   = 1'b1;
            for (int i = 0; i < 14; i++) begin
                w.en   = 1'b1;
                w.addr = 5'($random(seed)) | 5'd1;
                w.data = $random(seed);
                drive_cycle(w, '0);
                if (i == 4) csr_in.mtval = ~csr_in.mtval;
            end
            drive_cycle('0, '0);
            push_csr(csr_in, 6);   // Queued behind the whole burst
            repeat (20) @(posedge clk);
            stall_drops = drop_count - start_drops;
            hold_ack    = 1'b0;
            settle("stalled burst");
            allow_skip  = 1'b0;
            if (stall_drops == 16'd0) report_error("stall caused no drops");
            if (rx_reg_count - start_rx_reg + int'(stall_drops) != 14) begin
                report_error($sformatf("%0d received plus %0d dropped, 14 issued",
                                       rx_reg_count - start_rx_reg, stall_drops));
            end
            if (skipped - start_skip != int'(stall_drops)) begin
                report_error($sformatf("%0d records missing, drop_count says %0d",
                                       skipped - start_skip, stall_drops));
            end
            finish_test("stalled link", start_errors);
        end

        if (timed_out) $display("Run stopped early after a timeout");
        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
trace_pkg.sv
reg_shadow.sv
csr_snapshot.sv
trace_merge.sv
trace_fifo.sv
trace_link.sv
trace_top.sv
tb_clk_gen.sv
tb_trace_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the trace unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_trace_top -o sim_trace

out=$(./obj_dir/sim_trace)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
